// ==== common/csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;

    // csr numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // field positions
    localparam int PLV_LO            = 0;
    localparam int PLV_HI            = 1;
    localparam int IE_BIT            = 2;
    localparam int PIE_BIT           = 2;
    localparam int LIE_WIDTH         = 13;
    localparam int IS_SW_HI          = 1;
    localparam int IS_TIMER_BIT      = 11;
    localparam int EENTRY_VA_LO      = 12;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LO   = 2;
    localparam int TICLR_CLR_BIT     = 0;

    // bit 10 is reserved and stays zero
    localparam logic [LIE_WIDTH-1:0] LIE_WRITABLE = 13'h1bff;

    typedef logic [5:0] ecode_t;
    localparam ecode_t ECODE_INT  = 6'h00;
    localparam ecode_t ECODE_ADEF = 6'h08;
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_SYS  = 6'h0b;
    localparam ecode_t ECODE_BRK  = 6'h0c;
    localparam ecode_t ECODE_INE  = 6'h0d;

    // cause flags in the bit order of the exc port
    typedef struct packed {
        logic int_req;
        logic adef;
        logic ale;
        logic sys;
        logic brk;
        logic ine;
    } excp_t;

endpackage

// ==== common/csr_wr_if.sv ====
interface csr_wr_if
    import csr_pkg::*;
();
    logic     we;
    csr_num_t num;
    word_t    mask;
    word_t    value;

    // one masked write, taken at the next clk edge
    modport src (
        output we, num, mask, value
    );

    modport dst (
        input we, num, mask, value
    );

endinterface

// ==== excp/csr_excp_regs.sv ====
module csr_excp_regs
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    csr_wr_if.dst    wr,
    input  csr_num_t rd_num,
    input  excp_t    exc,
    input  logic     ertn_flush,
    input  word_t    wb_pc,
    input  word_t    wb_fault_vaddr,
    input  logic     timer_irq,
    output word_t    rd_data,
    output word_t    eentry_pc,
    output word_t    era_pc,
    output logic     has_int
);
    localparam int ESTAT_ECODE_LO = 16;

    logic [PLV_HI:PLV_LO]   crmd_plv;
    logic                   crmd_ie;
    logic [PLV_HI:PLV_LO]   prmd_pplv;
    logic                   prmd_pie;
    logic [LIE_WIDTH-1:0]   ecfg_lie;
    logic [IS_SW_HI:0]      estat_is_sw;
    ecode_t                 estat_ecode;
    word_t                  era;
    word_t                  badv;
    logic [31:EENTRY_VA_LO] eentry_va;

    logic [LIE_WIDTH-1:0] estat_is;
    word_t                crmd_word;
    word_t                prmd_word;
    word_t                ecfg_word;
    word_t                estat_word;
    word_t                eentry_word;
    word_t                wr_old;
    word_t                wr_new;
    logic                 exc_any;
    ecode_t               exc_ecode;

    // register images as software sees them
    always_comb begin
        crmd_word = '0;
        crmd_word[PLV_HI:PLV_LO] = crmd_plv;
        crmd_word[IE_BIT] = crmd_ie;
        prmd_word = '0;
        prmd_word[PLV_HI:PLV_LO] = prmd_pplv;
        prmd_word[PIE_BIT] = prmd_pie;
        ecfg_word = '0;
        ecfg_word[LIE_WIDTH-1:0] = ecfg_lie;
        // hardware and ipi lines are not wired
        estat_is = '0;
        estat_is[IS_SW_HI:0] = estat_is_sw;
        estat_is[IS_TIMER_BIT] = timer_irq;
        estat_word = '0;
        estat_word[LIE_WIDTH-1:0] = estat_is;
        estat_word[ESTAT_ECODE_LO +: $bits(ecode_t)] = estat_ecode;
        eentry_word = '0;
        eentry_word[31:EENTRY_VA_LO] = eentry_va;
    end

    always_comb begin
        case (wr.num)
            CSR_CRMD:   wr_old = crmd_word;
            CSR_PRMD:   wr_old = prmd_word;
            CSR_ECFG:   wr_old = ecfg_word;
            CSR_ESTAT:  wr_old = estat_word;
            CSR_ERA:    wr_old = era;
            CSR_EENTRY: wr_old = eentry_word;
            default:    wr_old = '0;
        endcase
    end

    assign wr_new  = (wr.mask & wr.value) | (~wr.mask & wr_old);
    assign exc_any = |exc;

    // cause priority
    always_comb begin
        if (exc.int_req)
            exc_ecode = ECODE_INT;
        else if (exc.adef)
            exc_ecode = ECODE_ADEF;
        else if (exc.sys)
            exc_ecode = ECODE_SYS;
        else if (exc.brk)
            exc_ecode = ECODE_BRK;
        else if (exc.ine)
            exc_ecode = ECODE_INE;
        else
            exc_ecode = ECODE_ALE;
    end

    // exception entry and ertn override software writes
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exc_any) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && wr.num == CSR_CRMD) begin
            crmd_plv <= wr_new[PLV_HI:PLV_LO];
            crmd_ie  <= wr_new[IE_BIT];
        end else if (wr.we && wr.num == CSR_PRMD) begin
            prmd_pplv <= wr_new[PLV_HI:PLV_LO];
            prmd_pie  <= wr_new[PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie    <= '0;
            estat_is_sw <= '0;
            estat_ecode <= ECODE_INT;
            era         <= '0;
            eentry_va   <= '0;
        end else begin
            if (wr.we && wr.num == CSR_ECFG)
                ecfg_lie <= wr_new[LIE_WIDTH-1:0] & LIE_WRITABLE;
            if (wr.we && wr.num == CSR_ESTAT)
                estat_is_sw <= wr_new[IS_SW_HI:0];
            if (wr.we && wr.num == CSR_EENTRY)
                eentry_va <= wr_new[31:EENTRY_VA_LO];
            if (exc_any) begin
                estat_ecode <= exc_ecode;
                era         <= wb_pc;
            end else if (wr.we && wr.num == CSR_ERA) begin
                era <= wr_new;
            end
        end
    end

    // fetch faults report the pc, memory faults the data address
    always_ff @(posedge clk) begin
        if (exc.adef || exc.ale)
            badv <= exc.adef ? wb_pc : wb_fault_vaddr;
    end

    always_comb begin
        case (rd_num)
            CSR_CRMD:   rd_data = crmd_word;
            CSR_PRMD:   rd_data = prmd_word;
            CSR_ECFG:   rd_data = ecfg_word;
            CSR_ESTAT:  rd_data = estat_word;
            CSR_ERA:    rd_data = era;
            CSR_BADV:   rd_data = badv;
            CSR_EENTRY: rd_data = eentry_word;
            default:    rd_data = '0;
        endcase
    end

    assign eentry_pc = eentry_word;
    assign era_pc    = era;
    assign has_int   = (|(estat_is & ecfg_lie)) & crmd_ie;

    // the pipeline retires either an exception or an ertn, never both
    a_no_ertn_with_exc: assert property (@(posedge clk) disable iff (!resetn)
        !(ertn_flush && exc_any));

endmodule

// ==== timer/csr_timer.sv ====
module csr_timer
    import csr_pkg::*;
#(
    parameter word_t CORE_ID = 32'h0
) (
    input  logic     clk,
    input  logic     resetn,
    csr_wr_if.dst    wr,
    input  csr_num_t rd_num,
    output word_t    rd_data,
    output logic     timer_irq
);
    // initval sits at the top of tcfg so clearing the low bits gives initval << 2
    localparam word_t INITVAL_MASK = ~word_t'((1 << TCFG_INITVAL_LO) - 1);

    word_t tid;
    word_t tcfg;
    word_t tval;
    word_t wr_old;
    word_t wr_new;
    logic  wr_tcfg;
    logic  ticlr_clr;
    logic  tval_hit;

    always_comb begin
        case (wr.num)
            CSR_TID:  wr_old = tid;
            CSR_TCFG: wr_old = tcfg;
            default:  wr_old = '0;
        endcase
    end

    assign wr_new    = (wr.mask & wr.value) | (~wr.mask & wr_old);
    assign wr_tcfg   = wr.we && wr.num == CSR_TCFG;
    assign ticlr_clr = wr.we && wr.num == CSR_TICLR
                       && wr.mask[TICLR_CLR_BIT] && wr.value[TICLR_CLR_BIT];
    assign tval_hit  = tcfg[TCFG_EN_BIT] && tval == '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tid  <= CORE_ID;
            tcfg <= '0;
        end else if (wr.we && wr.num == CSR_TID) begin
            tid <= wr_new;
        end else if (wr_tcfg) begin
            tcfg <= wr_new;
        end
    end

    // countdown that parks at all ones in one-shot mode
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tval <= '1;
        end else if (wr_tcfg && wr_new[TCFG_EN_BIT]) begin
            tval <= wr_new & INITVAL_MASK;
        end else if (tcfg[TCFG_EN_BIT] && tval != '1) begin
            if (tval_hit && tcfg[TCFG_PERIODIC_BIT])
                tval <= tcfg & INITVAL_MASK;
            else
                tval <= tval - 1'b1;
        end
    end

    // set beats clear
    always_ff @(posedge clk) begin
        if (!resetn)
            timer_irq <= 1'b0;
        else if (tval_hit)
            timer_irq <= 1'b1;
        else if (ticlr_clr)
            timer_irq <= 1'b0;
    end

    always_comb begin
        case (rd_num)
            CSR_TID:  rd_data = tid;
            CSR_TCFG: rd_data = tcfg;
            CSR_TVAL: rd_data = tval;
            default:  rd_data = '0;
        endcase
    end

    a_ticlr_clears: assert property (@(posedge clk) disable iff (!resetn)
        (ticlr_clr && tval != '0) |=> !timer_irq);

endmodule

// ==== verilog/csr_save_regs.sv ====
module csr_save_regs
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    csr_wr_if.dst    wr,
    input  csr_num_t rd_num,
    output word_t    rd_data
);
    word_t save_q [4];
    logic  wr_hit;
    logic  rd_hit;
    word_t wr_new;

    // SAVE0..SAVE3 share the upper number bits and the low two bits pick the slot
    assign wr_hit = wr.we && wr.num[13:2] == CSR_SAVE0[13:2];
    assign rd_hit = rd_num[13:2] == CSR_SAVE0[13:2];
    assign wr_new = (wr.mask & wr.value) | (~wr.mask & save_q[wr.num[1:0]]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr_hit) begin
            save_q[wr.num[1:0]] <= wr_new;
        end
    end

    assign rd_data = rd_hit ? save_q[rd_num[1:0]] : '0;

endmodule

// ==== verilog/csr_top.sv ====
module csr_top
    import csr_pkg::*;
#(
    parameter word_t CORE_ID = 32'h0
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     we,
    input  csr_num_t wr_num,
    input  word_t    wr_mask,
    input  word_t    wr_value,
    input  logic     rd_en,
    input  csr_num_t rd_num,
    input  excp_t    exc,
    input  logic     ertn_flush,
    input  word_t    wb_pc,
    input  word_t    wb_fault_vaddr,
    output word_t    rd_value,
    output word_t    eentry_pc,
    output word_t    era_pc,
    output logic     has_int
);
    word_t excp_rd;
    word_t timer_rd;
    word_t save_rd;
    logic  timer_irq;

    csr_wr_if wr_bus ();

    // write port onto the shared bus
    assign wr_bus.we    = we;
    assign wr_bus.num   = wr_num;
    assign wr_bus.mask  = wr_mask;
    assign wr_bus.value = wr_value;

    csr_excp_regs u_excp (
        .clk            (clk),
        .resetn         (resetn),
        .wr             (wr_bus.dst),
        .rd_num         (rd_num),
        .exc            (exc),
        .ertn_flush     (ertn_flush),
        .wb_pc          (wb_pc),
        .wb_fault_vaddr (wb_fault_vaddr),
        .timer_irq      (timer_irq),
        .rd_data        (excp_rd),
        .eentry_pc      (eentry_pc),
        .era_pc         (era_pc),
        .has_int        (has_int)
    );

    csr_timer #(
        .CORE_ID (CORE_ID)
    ) u_timer (
        .clk       (clk),
        .resetn    (resetn),
        .wr        (wr_bus.dst),
        .rd_num    (rd_num),
        .rd_data   (timer_rd),
        .timer_irq (timer_irq)
    );

    csr_save_regs u_save (
        .clk     (clk),
        .resetn  (resetn),
        .wr      (wr_bus.dst),
        .rd_num  (rd_num),
        .rd_data (save_rd)
    );

    // blocks return zero for numbers they do not own
    assign rd_value = {32{rd_en}} & (excp_rd | timer_rd | save_rd);

endmodule

// ==== tb/csr_model.svh ====
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// shadow of the architectural state that follows the stimulus
word_t  sh_crmd;
word_t  sh_prmd;
word_t  sh_ecfg;
logic [1:0] sh_is_sw;
ecode_t sh_ecode;
word_t  sh_era;
word_t  sh_badv;
word_t  sh_eentry;
word_t  sh_save [4];
word_t  sh_tid;
word_t  sh_tcfg;
word_t  sh_tval;
logic   sh_tirq;

function automatic void reset_shadow(input word_t core_id);
    sh_crmd = '0;
    sh_prmd = '0;
    sh_ecfg = '0;
    sh_is_sw = '0;
    sh_ecode = ECODE_INT;
    sh_era = '0;
    sh_badv = '0;
    sh_eentry = '0;
    for (int i = 0; i < 4; i++) begin
        sh_save[i] = '0;
    end
    sh_tid = core_id;
    sh_tcfg = '0;
    sh_tval = '1;
    sh_tirq = 1'b0;
endfunction

function automatic word_t masked_merge(input word_t old, input word_t mask, input word_t value);
    return (value & mask) | (old & ~mask);
endfunction

// int_req first, ale last
function automatic ecode_t ecode_priority(input excp_t e);
    if (e.int_req)
        return ECODE_INT;
    if (e.adef)
        return ECODE_ADEF;
    if (e.sys)
        return ECODE_SYS;
    if (e.brk)
        return ECODE_BRK;
    if (e.ine)
        return ECODE_INE;
    return ECODE_ALE;
endfunction

function automatic word_t badv_choice(input excp_t e, input word_t pc, input word_t va,
                                      input word_t old);
    if (e.adef)
        return pc;
    if (e.ale)
        return va;
    return old;
endfunction

// load is initval << 2
// the zero value is held for one edge before reload or stop
function automatic word_t timer_after(input int load, input int k, input logic periodic);
    if (periodic)
        return word_t'(load - (k % (load + 1)));
    if (k > load)
        return '1;
    return word_t'(load - k);
endfunction

function automatic word_t shadow_read(input csr_num_t num);
    word_t r;
    r = '0;
    case (num)
        CSR_CRMD:   r = sh_crmd;
        CSR_PRMD:   r = sh_prmd;
        CSR_ECFG:   r = sh_ecfg;
        CSR_ESTAT: begin
            r[1:0]   = sh_is_sw;
            r[11]    = sh_tirq;
            r[21:16] = sh_ecode;
        end
        CSR_ERA:    r = sh_era;
        CSR_BADV:   r = sh_badv;
        CSR_EENTRY: r = sh_eentry;
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
            r = sh_save[num[1:0]];
        CSR_TID:    r = sh_tid;
        CSR_TCFG:   r = sh_tcfg;
        CSR_TVAL:   r = sh_tval;
        default:    r = '0;
    endcase
    return r;
endfunction

function automatic logic pending_irq();
    word_t estat;
    estat = shadow_read(CSR_ESTAT);
    return (|(estat[12:0] & sh_ecfg[12:0])) & sh_crmd[2];
endfunction

function automatic void update_shadow(input csr_num_t num, input word_t mask,
                                      input word_t value);
    word_t m;
    m = masked_merge(shadow_read(num), mask, value);
    case (num)
        CSR_CRMD:   sh_crmd = m & 32'h7;
        CSR_PRMD:   sh_prmd = m & 32'h7;
        // lie bit 10 reads zero
        CSR_ECFG:   sh_ecfg = m & 32'h0000_1bff;
        CSR_ESTAT:  sh_is_sw = m[1:0];
        CSR_ERA:    sh_era = m;
        CSR_EENTRY: sh_eentry = m & 32'hffff_f000;
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
            sh_save[num[1:0]] = m;
        CSR_TID:    sh_tid = m;
        CSR_TCFG: begin
            sh_tcfg = m;
            if (m[0])
                sh_tval = m & 32'hffff_fffc;
        end
        CSR_TICLR: begin
            if (mask[0] && value[0])
                sh_tirq = 1'b0;
        end
        default: ;
    endcase
endfunction

function automatic void apply_exc(input excp_t e, input word_t pc, input word_t va);
    sh_prmd  = sh_crmd & 32'h7;
    sh_crmd  = '0;
    sh_ecode = ecode_priority(e);
    sh_era   = pc;
    sh_badv  = badv_choice(e, pc, va, sh_badv);
endfunction

`endif

// ==== tb/csr_tb.sv ====
module csr_tb
    import csr_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD     = 40;
    localparam int    DRIVE_DELAY    = 2;
    localparam int    TIMEOUT_CYCLES = 3000;
    localparam word_t CORE_ID        = 32'h0000_0a5c;
    localparam int    SEED           = 32'h26a7_29f9;

    logic     clk;
    logic     resetn;
    logic     we;
    csr_num_t wr_num;
    word_t    wr_mask;
    word_t    wr_value;
    logic     rd_en;
    csr_num_t rd_num;
    excp_t    exc;
    logic     ertn_flush;
    word_t    wb_pc;
    word_t    wb_fault_vaddr;
    word_t    rd_value;
    word_t    eentry_pc;
    word_t    era_pc;
    logic     has_int;

    int    seed;
    int    n_tests;
    int    n_checks;
    int    n_errors;
    int    err_at_start;
    string cur_test;
    logic  chk_rd;
    logic  chk_out;

    `include "csr_model.svh"

    csr_top #(
        .CORE_ID (CORE_ID)
    ) dut0 (
        .clk            (clk),
        .resetn         (resetn),
        .we             (we),
        .wr_num         (wr_num),
        .wr_mask        (wr_mask),
        .wr_value       (wr_value),
        .rd_en          (rd_en),
        .rd_num         (rd_num),
        .exc            (exc),
        .ertn_flush     (ertn_flush),
        .wb_pc          (wb_pc),
        .wb_fault_vaddr (wb_fault_vaddr),
        .rd_value       (rd_value),
        .eentry_pc      (eentry_pc),
        .era_pc         (era_pc),
        .has_int        (has_int)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // sample just before the next rising edge
    always begin : compare
        word_t exp_rd;
        logic  exp_int;
        @(posedge clk);
        #(CLK_PERIOD - 1);
        if (chk_rd) begin
            exp_rd = rd_en ? shadow_read(rd_num) : '0;
            n_checks++;
            if (rd_value !== exp_rd) begin
                $display("CHECK FAILED %s rd_value[%h]: expected %h, actual %h",
                         cur_test, rd_num, exp_rd, rd_value);
                n_errors++;
            end
        end
        if (chk_out) begin
            exp_int = pending_irq();
            n_checks += 3;
            if (has_int !== exp_int) begin
                $display("CHECK FAILED %s has_int: expected %b, actual %b",
                         cur_test, exp_int, has_int);
                n_errors++;
            end
            if (era_pc !== sh_era) begin
                $display("CHECK FAILED %s era_pc: expected %h, actual %h",
                         cur_test, sh_era, era_pc);
                n_errors++;
            end
            if (eentry_pc !== sh_eentry) begin
                $display("CHECK FAILED %s eentry_pc: expected %h, actual %h",
                         cur_test, sh_eentry, eentry_pc);
                n_errors++;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d clock periods", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    task automatic start_test(input string name);
        cur_test = name;
        err_at_start = n_errors;
        n_tests++;
    endtask

    task automatic end_test();
        $display("test %s: %s, %0d errors", cur_test,
                 (n_errors == err_at_start) ? "ok" : "FAILED", n_errors - err_at_start);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic write_csr(input csr_num_t num, input word_t mask, input word_t value);
        we = 1'b1;
        wr_num = num;
        wr_mask = mask;
        wr_value = value;
        next_cycle();
        we = 1'b0;
        update_shadow(num, mask, value);
    endtask

    task automatic check_read(input csr_num_t num);
        rd_num = num;
        chk_rd = 1'b1;
        next_cycle();
        chk_rd = 1'b0;
    endtask

    task automatic raise_exc(input excp_t e, input word_t pc, input word_t va);
        exc = e;
        wb_pc = pc;
        wb_fault_vaddr = va;
        next_cycle();
        exc = '0;
        apply_exc(e, pc, va);
    endtask

    task automatic pulse_ertn();
        ertn_flush = 1'b1;
        next_cycle();
        ertn_flush = 1'b0;
        sh_crmd = sh_prmd & 32'h7;
    endtask

    task automatic reset_values();
        csr_num_t regs [11] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ERA, CSR_SAVE0,
                                CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TCFG, CSR_TVAL, CSR_TID};
        start_test("reset");
        foreach (regs[i]) begin
            check_read(regs[i]);
        end
        // rd_en low forces zero
        rd_en = 1'b0;
        check_read(CSR_TID);
        rd_en = 1'b1;
        end_test();
    endtask

    task automatic masked_writes();
        csr_num_t regs [7] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                               CSR_EENTRY, CSR_ECFG, CSR_PRMD};
        word_t    mask;
        word_t    value;
        start_test("masked_write");
        for (int round = 0; round < 4; round++) begin
            foreach (regs[i]) begin
                mask = $random(seed);
                value = $random(seed);
                write_csr(regs[i], mask, value);
                check_read(regs[i]);
            end
        end
        end_test();
    endtask

    task automatic exception_entry();
        word_t r;
        excp_t e;
        start_test("exception");
        for (int i = 0; i < 8; i++) begin
            write_csr(CSR_CRMD, '1, 32'h7);
            r = $random(seed);
            e = r[5:0];
            if (e == '0)
                e = 6'h01;
            raise_exc(e, $random(seed), $random(seed));
            check_read(CSR_CRMD);
            check_read(CSR_PRMD);
            check_read(CSR_ERA);
            check_read(CSR_ESTAT);
            if (e.adef || e.ale)
                check_read(CSR_BADV);
        end
        end_test();
    endtask

    task automatic ertn_return();
        start_test("ertn");
        write_csr(CSR_CRMD, '1, 32'h7);
        raise_exc(6'b000100, 32'h1c00_0040, 32'h0);
        check_read(CSR_CRMD);
        pulse_ertn();
        check_read(CSR_CRMD);
        check_read(CSR_PRMD);
        write_csr(CSR_PRMD, '1, 32'h1);
        pulse_ertn();
        check_read(CSR_CRMD);
        end_test();
    endtask

    task automatic interrupt_request();
        start_test("interrupt");
        for (int i = 0; i < 16; i++) begin
            write_csr(CSR_ESTAT, 32'h3, $random(seed));
            write_csr(CSR_ECFG, $random(seed), $random(seed));
            write_csr(CSR_CRMD, 32'h4, ~sh_crmd);
            check_read(CSR_ESTAT);
        end
        end_test();
    endtask

    // TVAL compared every cycle while the countdown runs
    task automatic track_tval(input int load, input logic periodic, input int edges);
        rd_num = CSR_TVAL;
        chk_rd = 1'b1;
        for (int k = 1; k <= edges; k++) begin
            next_cycle();
            sh_tval = timer_after(load, k, periodic);
            if (k > load)
                sh_tirq = 1'b1;
        end
        chk_rd = 1'b0;
    endtask

    task automatic timer_countdown();
        start_test("timer");
        write_csr(CSR_ECFG, '1, 32'h800);
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        write_csr(CSR_CRMD, '1, 32'h4);
        // one-shot with initval 5
        write_csr(CSR_TCFG, '1, 32'h15);
        track_tval(20, 1'b0, 24);
        check_read(CSR_ESTAT);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        check_read(CSR_ESTAT);
        // periodic with initval 3
        write_csr(CSR_TCFG, '1, 32'hf);
        track_tval(12, 1'b1, 28);
        check_read(CSR_ESTAT);
        end_test();
    endtask

    initial begin
        seed = SEED;
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        err_at_start = 0;
        cur_test = "none";
        chk_rd = 1'b0;
        chk_out = 1'b0;
        clk = 1'b0;
        resetn = 1'b0;
        we = 1'b0;
        wr_num = '0;
        wr_mask = '0;
        wr_value = '0;
        rd_en = 1'b0;
        rd_num = '0;
        exc = '0;
        ertn_flush = 1'b0;
        wb_pc = '0;
        wb_fault_vaddr = '0;
        reset_shadow(CORE_ID);
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        resetn = 1'b1;
        rd_en = 1'b1;
        chk_out = 1'b1;
        reset_values();
        masked_writes();
        exception_entry();
        ertn_return();
        interrupt_request();
        timer_countdown();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== csr_regfile.f ====
+incdir+tb
common/csr_pkg.sv
common/csr_wr_if.sv
excp/csr_excp_regs.sv
timer/csr_timer.sv
verilog/csr_save_regs.sv
verilog/csr_top.sv
tb/csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_tb -f csr_regfile.f -o csr_sim

out=$(./obj_dir/csr_sim || true)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
